// File: run_sim.sh
#!/bin/sh
# Build and run the register path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_shell_cl -f tb.f
sim_out=$(./obj_dir/Vtb_shell_cl)
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

// File: source/axi_lite_pkg.sv
// AXI-Lite widths, responses and queued commands

`default_nettype none

package axi_lite_pkg;

   // ----------------------------------------
   // Bus widths
   // ----------------------------------------
   localparam int unsigned AXI_ADDR_W = 32;
   localparam int unsigned AXI_DATA_W = 32;

   // ----------------------------------------
   // Response codes on B and R
   // ----------------------------------------
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // ----------------------------------------
   // Queued host commands
   // ----------------------------------------
   // One write is an address and a data word
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_DATA_W-1:0] data;
   } wr_cmd_t;

   // One read is an address only
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
   } rd_cmd_t;

endpackage

`default_nettype wire

// File: source/cl_axi_slave.sv
// Custom logic AXI-Lite slave

`timescale 1ns/1ps
`default_nettype none

module cl_axi_slave
   import axi_lite_pkg::*;
(
   input  wire                   clk_out,
   input  wire                   arst_n_i,
   // AXI slave side
   input  wire  [AXI_ADDR_W-1:0] s_awaddr_i,
   input  wire                   s_awvalid_i,
   output logic                  s_awready_o,
   input  wire  [AXI_DATA_W-1:0] s_wdata_i,
   input  wire                   s_wvalid_i,
   output logic                  s_wready_o,
   output axi_resp_t             s_bresp_o,
   output logic                  s_bvalid_o,
   input  wire                   s_bready_i,
   input  wire  [AXI_ADDR_W-1:0] s_araddr_i,
   input  wire                   s_arvalid_i,
   output logic                  s_arready_o,
   output logic [AXI_DATA_W-1:0] s_rdata_o,
   output axi_resp_t             s_rresp_o,
   output logic                  s_rvalid_o,
   input  wire                   s_rready_i,
   // Register access
   output logic                  reg_wr_o,
   output logic                  reg_rd_o,
   output logic [AXI_ADDR_W-1:0] reg_addr_o,
   output logic [AXI_DATA_W-1:0] reg_wdata_o,
   input  wire  [AXI_DATA_W-1:0] reg_rdata_i,
   input  wire                   reg_err_i
);

   logic [AXI_ADDR_W-1:0] awaddr_q;
   logic                  aw_full_q;
   logic                  w_full_q;
   logic                  aw_xfer, w_xfer;
   logic                  wr_go, rd_go;
   axi_resp_t             err_resp;

   // ----------------------------------------
   // Write path
   // ----------------------------------------
   // AW and W are taken independently, then written together
   assign s_awready_o = !aw_full_q && !s_bvalid_o;
   assign s_wready_o  = !w_full_q && !s_bvalid_o;
   assign aw_xfer     = s_awvalid_i && s_awready_o;
   assign w_xfer      = s_wvalid_i && s_wready_o;
   assign wr_go       = aw_full_q && w_full_q;

   // ----------------------------------------
   // Read path
   // ----------------------------------------
   // Write has the register port this cycle
   assign s_arready_o = !s_rvalid_o && !wr_go;
   assign rd_go       = s_arvalid_i && s_arready_o;

   assign reg_wr_o   = wr_go;
   assign reg_rd_o   = rd_go;
   assign reg_addr_o = wr_go ? awaddr_q : s_araddr_i;
   assign err_resp   = reg_err_i ? RESP_SLVERR : RESP_OKAY;

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         aw_full_q  <= 1'b0;
         w_full_q   <= 1'b0;
         s_bvalid_o <= 1'b0;
         s_rvalid_o <= 1'b0;
      end else begin
         if (wr_go) begin
            aw_full_q  <= 1'b0;
            w_full_q   <= 1'b0;
            s_bvalid_o <= 1'b1;
         end else begin
            aw_full_q <= aw_full_q || aw_xfer;
            w_full_q  <= w_full_q || w_xfer;
            if (s_bready_i) begin
               s_bvalid_o <= 1'b0;
            end
         end
         if (rd_go) begin
            s_rvalid_o <= 1'b1;
         end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
         end
      end
   end

   // Captured write and response payload
   always_ff @(posedge clk_out) begin
      if (aw_xfer) begin
         awaddr_q <= s_awaddr_i;
      end
      if (w_xfer) begin
         reg_wdata_o <= s_wdata_i;
      end
      if (wr_go) begin
         s_bresp_o <= err_resp;
      end
      if (rd_go) begin
         s_rdata_o <= reg_rdata_i;
         s_rresp_o <= err_resp;
      end
   end

endmodule

`default_nettype wire

// File: source/cl_reg_block.sv
// Custom logic register block

`timescale 1ns/1ps
`default_nettype none

module cl_reg_block
   import axi_lite_pkg::*, cl_reg_pkg::*;
(
   input  wire                   clk_out,
   input  wire                   arst_n_i,
   input  wire                   reg_wr_i,
   input  wire                   reg_rd_i,
   input  wire  [AXI_ADDR_W-1:0] reg_addr_i,
   input  wire  [AXI_DATA_W-1:0] reg_wdata_i,
   output logic [AXI_DATA_W-1:0] reg_rdata_o,
   output logic                  reg_err_o,
   input  wire  [AXI_DATA_W-1:0] cl_status_i,
   output logic [AXI_DATA_W-1:0] cl_ctl_o
);

   logic [AXI_DATA_W-1:0] ctl0_q, ctl1_q, status_q;
   logic [AXI_DATA_W-1:0] scratch0_q, scratch1_q, count_q;
   logic [AXI_DATA_W-1:0] rd_mux;
   logic                  mapped;
   logic                  read_only;
   logic                  wr_ok;

   // ----------------------------------------
   // Address decode
   // ----------------------------------------
   always_comb begin
      mapped    = 1'b1;
      read_only = 1'b0;
      rd_mux    = '0;
      case (reg_addr_i)
         REG_ID: begin
            rd_mux    = CL_ID_VALUE;
            read_only = 1'b1;
         end
         REG_CTL0:     rd_mux = ctl0_q;
         REG_CTL1:     rd_mux = ctl1_q;
         REG_STATUS: begin
            rd_mux    = status_q;
            read_only = 1'b1;
         end
         REG_SCRATCH0: rd_mux = scratch0_q;
         REG_SCRATCH1: rd_mux = scratch1_q;
         REG_COUNT: begin
            rd_mux    = count_q;
            read_only = 1'b1;
         end
         default:      mapped = 1'b0;
      endcase
   end

   assign wr_ok       = reg_wr_i && mapped && !read_only;
   assign reg_err_o   = (reg_wr_i || reg_rd_i) && (!mapped || (reg_wr_i && read_only));
   assign reg_rdata_o = (reg_rd_i && mapped) ? rd_mux : '0;
   assign cl_ctl_o    = ctl1_q;

   // ----------------------------------------
   // Writable registers and status sample
   // ----------------------------------------
   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctl0_q     <= '0;
         ctl1_q     <= '0;
         status_q   <= '0;
         scratch0_q <= '0;
         scratch1_q <= '0;
      end else begin
         status_q <= cl_status_i;
         if (wr_ok && reg_addr_i == REG_CTL0)     ctl0_q     <= reg_wdata_i;
         if (wr_ok && reg_addr_i == REG_CTL1)     ctl1_q     <= reg_wdata_i;
         if (wr_ok && reg_addr_i == REG_SCRATCH0) scratch0_q <= reg_wdata_i;
         if (wr_ok && reg_addr_i == REG_SCRATCH1) scratch1_q <= reg_wdata_i;
      end
   end

   // Event counter where clear wins over enable
   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else if (ctl0_q[CTL0_CNT_CLR]) begin
         count_q <= '0;
      end else if (ctl0_q[CTL0_CNT_EN]) begin
         count_q <= count_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/cl_reg_pkg.sv
// Custom logic register map

`default_nettype none

package cl_reg_pkg;

   // ----------------------------------------
   // Register offsets
   // ----------------------------------------
   localparam logic [31:0] REG_ID       = 32'h0000_0000;
   localparam logic [31:0] REG_CTL0     = 32'h0000_0004;
   localparam logic [31:0] REG_CTL1     = 32'h0000_0008;
   localparam logic [31:0] REG_STATUS   = 32'h0000_000C;
   localparam logic [31:0] REG_SCRATCH0 = 32'h0000_0010;
   localparam logic [31:0] REG_SCRATCH1 = 32'h0000_0014;
   localparam logic [31:0] REG_COUNT    = 32'h0000_0018;

   // Fixed identity word
   localparam logic [31:0] CL_ID_VALUE = 32'hC15E_0001;

   // ----------------------------------------
   // Control word 0 bits
   // ----------------------------------------
   // Counter runs while set
   localparam int unsigned CTL0_CNT_EN  = 0;
   // Counter held at zero while set
   localparam int unsigned CTL0_CNT_CLR = 1;

endpackage

`default_nettype wire

// File: source/cmd_fifo.sv
// Synchronous command queue

`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
   parameter type         payload_t = logic [31:0],
   parameter int unsigned DEPTH     = 4
) (
   input  wire      clk_out,
   input  wire      arst_n_i,
   input  wire      push_i,
   input  payload_t push_data_i,
   input  wire      pop_i,
   output payload_t head_o,
   output logic     empty_o,
   output logic     full_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == CNT_W'(DEPTH));
   assign head_o  = mem[rd_ptr_q];

   // A full queue still takes a push in a popping cycle
   assign do_pop  = pop_i && !empty_o;
   assign do_push = push_i && (!full_o || do_pop);

   always_ff @(posedge clk_out) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/host_access_engine.sv
// Host register access engine
// AXI-Lite master with request queues

`timescale 1ns/1ps
`default_nettype none

module host_access_engine
   import axi_lite_pkg::*;
#(
   parameter int unsigned FIFO_DEPTH = 4
) (
   input  wire                   clk_out,
   input  wire                   arst_n_i,
   // Host request and completion
   input  wire                   req_valid_i,
   input  wire                   req_write_i,
   input  wire  [AXI_ADDR_W-1:0] req_addr_i,
   input  wire  [AXI_DATA_W-1:0] req_wdata_i,
   output logic                  req_ready_o,
   output logic                  wr_done_o,
   output axi_resp_t             wr_resp_o,
   output logic                  rd_valid_o,
   output logic [AXI_DATA_W-1:0] rd_data_o,
   output axi_resp_t             rd_resp_o,
   // AXI master side
   output logic [AXI_ADDR_W-1:0] m_awaddr_o,
   output logic                  m_awvalid_o,
   input  wire                   m_awready_i,
   output logic [AXI_DATA_W-1:0] m_wdata_o,
   output logic                  m_wvalid_o,
   input  wire                   m_wready_i,
   input  axi_resp_t             m_bresp_i,
   input  wire                   m_bvalid_i,
   output logic                  m_bready_o,
   output logic [AXI_ADDR_W-1:0] m_araddr_o,
   output logic                  m_arvalid_o,
   input  wire                   m_arready_i,
   input  wire  [AXI_DATA_W-1:0] m_rdata_i,
   input  axi_resp_t             m_rresp_i,
   input  wire                   m_rvalid_i,
   output logic                  m_rready_o
);

   wr_cmd_t wr_head;
   rd_cmd_t rd_head;
   logic    wr_empty, wr_full, wr_push, wr_pop;
   logic    rd_empty, rd_full, rd_push, rd_pop;
   logic    aw_done_q, w_done_q;
   logic    aw_xfer, w_xfer;
   logic    b_xfer, r_xfer;

   // ----------------------------------------
   // Request split
   // ----------------------------------------
   assign req_ready_o = req_write_i ? !wr_full : !rd_full;
   assign wr_push     = req_valid_i && req_ready_o && req_write_i;
   assign rd_push     = req_valid_i && req_ready_o && !req_write_i;

   cmd_fifo #(.payload_t(wr_cmd_t), .DEPTH(FIFO_DEPTH)) u_wr_q (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .push_i      (wr_push),
      .push_data_i ('{addr: req_addr_i, data: req_wdata_i}),
      .pop_i       (wr_pop),
      .head_o      (wr_head),
      .empty_o     (wr_empty),
      .full_o      (wr_full)
   );

   cmd_fifo #(.payload_t(rd_cmd_t), .DEPTH(FIFO_DEPTH)) u_rd_q (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .push_i      (rd_push),
      .push_data_i ('{addr: req_addr_i}),
      .pop_i       (rd_pop),
      .head_o      (rd_head),
      .empty_o     (rd_empty),
      .full_o      (rd_full)
   );

   // ----------------------------------------
   // AW, W and AR from the queue heads
   // ----------------------------------------
   assign m_awaddr_o  = wr_head.addr;
   assign m_wdata_o   = wr_head.data;
   assign m_awvalid_o = !wr_empty && !aw_done_q;
   assign m_wvalid_o  = !wr_empty && !w_done_q;
   assign aw_xfer     = m_awvalid_o && m_awready_i;
   assign w_xfer      = m_wvalid_o && m_wready_i;

   // Head leaves once both halves of the write are through
   assign wr_pop = (aw_done_q || aw_xfer) && (w_done_q || w_xfer);

   assign m_araddr_o  = rd_head.addr;
   assign m_arvalid_o = !rd_empty;
   assign rd_pop      = m_arvalid_o && m_arready_i;

   assign b_xfer = m_bvalid_i && m_bready_o;
   assign r_xfer = m_rvalid_i && m_rready_o;

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         aw_done_q  <= 1'b0;
         w_done_q   <= 1'b0;
         m_bready_o <= 1'b0;
         m_rready_o <= 1'b0;
         wr_done_o  <= 1'b0;
         rd_valid_o <= 1'b0;
      end else begin
         aw_done_q  <= !wr_pop && (aw_done_q || aw_xfer);
         w_done_q   <= !wr_pop && (w_done_q || w_xfer);
         m_bready_o <= 1'b1;
         m_rready_o <= 1'b1;
         wr_done_o  <= b_xfer;
         rd_valid_o <= r_xfer;
      end
   end

   // Completion payload
   always_ff @(posedge clk_out) begin
      if (b_xfer) begin
         wr_resp_o <= m_bresp_i;
      end
      if (r_xfer) begin
         rd_data_o <= m_rdata_i;
         rd_resp_o <= m_rresp_i;
      end
   end

endmodule

`default_nettype wire

// File: source/shell_cl_top.sv
// Shell to custom logic register path

`timescale 1ns/1ps
`default_nettype none

module shell_cl_top
   import axi_lite_pkg::*;
#(
   parameter int unsigned FIFO_DEPTH = 4
) (
   input  wire                   clk_out,
   input  wire                   arst_n_i,
   input  wire                   req_valid_i,
   input  wire                   req_write_i,
   input  wire  [AXI_ADDR_W-1:0] req_addr_i,
   input  wire  [AXI_DATA_W-1:0] req_wdata_i,
   output logic                  req_ready_o,
   output logic                  wr_done_o,
   output axi_resp_t             wr_resp_o,
   output logic                  rd_valid_o,
   output logic [AXI_DATA_W-1:0] rd_data_o,
   output axi_resp_t             rd_resp_o,
   input  wire  [AXI_DATA_W-1:0] cl_status_i,
   output logic [AXI_DATA_W-1:0] cl_ctl_o
);

   // ----------------------------------------
   // AXI-Lite between engine and slave
   // ----------------------------------------
   logic [AXI_ADDR_W-1:0] awaddr, araddr;
   logic [AXI_DATA_W-1:0] wdata, rdata;
   axi_resp_t             bresp, rresp;
   logic                  awvalid, awready, wvalid, wready;
   logic                  bvalid, bready, arvalid, arready;
   logic                  rvalid, rready;

   // Register port
   logic [AXI_ADDR_W-1:0] reg_addr;
   logic [AXI_DATA_W-1:0] reg_wdata, reg_rdata;
   logic                  reg_wr, reg_rd, reg_err;

   host_access_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_host_access_engine (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_ready_o (req_ready_o),
      .wr_done_o   (wr_done_o),
      .wr_resp_o   (wr_resp_o),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o),
      .rd_resp_o   (rd_resp_o),
      .m_awaddr_o  (awaddr),
      .m_awvalid_o (awvalid),
      .m_awready_i (awready),
      .m_wdata_o   (wdata),
      .m_wvalid_o  (wvalid),
      .m_wready_i  (wready),
      .m_bresp_i   (bresp),
      .m_bvalid_i  (bvalid),
      .m_bready_o  (bready),
      .m_araddr_o  (araddr),
      .m_arvalid_o (arvalid),
      .m_arready_i (arready),
      .m_rdata_i   (rdata),
      .m_rresp_i   (rresp),
      .m_rvalid_i  (rvalid),
      .m_rready_o  (rready)
   );

   cl_axi_slave u_cl_axi_slave (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .s_awaddr_i  (awaddr),
      .s_awvalid_i (awvalid),
      .s_awready_o (awready),
      .s_wdata_i   (wdata),
      .s_wvalid_i  (wvalid),
      .s_wready_o  (wready),
      .s_bresp_o   (bresp),
      .s_bvalid_o  (bvalid),
      .s_bready_i  (bready),
      .s_araddr_i  (araddr),
      .s_arvalid_i (arvalid),
      .s_arready_o (arready),
      .s_rdata_o   (rdata),
      .s_rresp_o   (rresp),
      .s_rvalid_o  (rvalid),
      .s_rready_i  (rready),
      .reg_wr_o    (reg_wr),
      .reg_rd_o    (reg_rd),
      .reg_addr_o  (reg_addr),
      .reg_wdata_o (reg_wdata),
      .reg_rdata_i (reg_rdata),
      .reg_err_i   (reg_err)
   );

   cl_reg_block u_cl_reg_block (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .reg_wr_i    (reg_wr),
      .reg_rd_i    (reg_rd),
      .reg_addr_i  (reg_addr),
      .reg_wdata_i (reg_wdata),
      .reg_rdata_o (reg_rdata),
      .reg_err_o   (reg_err),
      .cl_status_i (cl_status_i),
      .cl_ctl_o    (cl_ctl_o)
   );

endmodule

`default_nettype wire

// File: tb.f
source/axi_lite_pkg.sv
source/cl_reg_pkg.sv
source/cmd_fifo.sv
source/host_access_engine.sv
source/cl_axi_slave.sv
source/cl_reg_block.sv
source/shell_cl_top.sv
tb/tb_shell_cl.sv

// File: tb/tb_shell_cl.sv
// Register path testbench

`timescale 1ns/1ps
`default_nettype none

module tb_shell_cl
   import axi_lite_pkg::*, cl_reg_pkg::*;
();

   localparam int unsigned FIFO_DEPTH      = 4;
   localparam int unsigned N_STEPS         = 19;
   localparam int unsigned CYCLES_PER_STEP = 200;
   localparam logic [31:0] SEED            = 32'h452a;
   localparam logic [31:0] STATUS_VALUE    = 32'h5a3c_0f96;
   localparam logic [31:0] UNMAPPED_ADDR   = 32'h0000_0040;

   // Operations
   localparam int OP_WR    = 0;
   localparam int OP_RD    = 1;
   localparam int OP_BURST = 2;

   // Compare modes for the completion
   localparam int CMP_NONE = 0;
   localparam int CMP_EQ   = 1;
   localparam int CMP_SAME = 2;
   localparam int CMP_MORE = 3;
   localparam int CMP_CTL  = 4;

   logic                  clk_out = 1'b0;
   logic                  arst_n_i;
   logic                  req_valid_i;
   logic                  req_write_i;
   logic [AXI_ADDR_W-1:0] req_addr_i;
   logic [AXI_DATA_W-1:0] req_wdata_i;
   logic                  req_ready_o;
   logic                  wr_done_o;
   axi_resp_t             wr_resp_o;
   logic                  rd_valid_o;
   logic [AXI_DATA_W-1:0] rd_data_o;
   axi_resp_t             rd_resp_o;
   logic [AXI_DATA_W-1:0] cl_status_i;
   logic [AXI_DATA_W-1:0] cl_ctl_o;

   // Stimulus table
   int          op_tab    [N_STEPS];
   logic [31:0] addr_tab  [N_STEPS];
   logic [31:0] wdata_tab [N_STEPS];
   logic [31:0] exp_tab   [N_STEPS];
   int          mode_tab  [N_STEPS];
   axi_resp_t   resp_tab  [N_STEPS];
   string       label_tab [N_STEPS];

   int          n_built;
   int          step_err;
   int          pass_cnt;
   int          fail_cnt;
   logic [31:0] rnd_state;
   logic [31:0] last_rd;

   shell_cl_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_shell_cl_top (
      .clk_out     (clk_out),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_ready_o (req_ready_o),
      .wr_done_o   (wr_done_o),
      .wr_resp_o   (wr_resp_o),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o),
      .rd_resp_o   (rd_resp_o),
      .cl_status_i (cl_status_i),
      .cl_ctl_o    (cl_ctl_o)
   );

   always #50 clk_out = ~clk_out;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   task automatic add_step(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp, input int mode, input axi_resp_t resp,
                           input string label);
      op_tab[n_built]    = op;
      addr_tab[n_built]  = addr;
      wdata_tab[n_built] = wdata;
      exp_tab[n_built]   = exp;
      mode_tab[n_built]  = mode;
      resp_tab[n_built]  = resp;
      label_tab[n_built] = label;
      n_built++;
   endtask

   task automatic build_table();
      logic [31:0] s0;
      logic [31:0] s1;
      logic [31:0] ctl_val;
      logic [31:0] id_val;
      s0      = next_random();
      s1      = next_random();
      ctl_val = next_random();
      id_val  = next_random();
      n_built = 0;
      add_step(OP_RD, REG_ID, '0, CL_ID_VALUE, CMP_EQ, RESP_OKAY, "id read");
      add_step(OP_WR, REG_SCRATCH0, s0, '0, CMP_NONE, RESP_OKAY, "scratch0 write");
      add_step(OP_WR, REG_SCRATCH1, s1, '0, CMP_NONE, RESP_OKAY, "scratch1 write");
      add_step(OP_RD, REG_SCRATCH0, '0, s0, CMP_EQ, RESP_OKAY, "scratch0 read");
      add_step(OP_RD, REG_SCRATCH1, '0, s1, CMP_EQ, RESP_OKAY, "scratch1 read");
      add_step(OP_WR, REG_CTL1, ctl_val, '0, CMP_CTL, RESP_OKAY, "ctl1 write");
      add_step(OP_RD, REG_STATUS, '0, STATUS_VALUE, CMP_EQ, RESP_OKAY, "status read");
      add_step(OP_RD, UNMAPPED_ADDR, '0, '0, CMP_EQ, RESP_SLVERR, "unmapped read");
      add_step(OP_WR, REG_ID, id_val, '0, CMP_NONE, RESP_SLVERR, "id write");
      add_step(OP_RD, REG_ID, '0, CL_ID_VALUE, CMP_EQ, RESP_OKAY, "id read again");
      // Counter runs first, then is held in clear and released with enable off
      add_step(OP_WR, REG_CTL0, 32'h1 << CTL0_CNT_EN, '0, CMP_NONE, RESP_OKAY,
               "counter run");
      add_step(OP_WR, REG_CTL0, 32'h1 << CTL0_CNT_CLR, '0, CMP_NONE, RESP_OKAY,
               "counter clear");
      add_step(OP_WR, REG_CTL0, '0, '0, CMP_NONE, RESP_OKAY, "counter stop");
      add_step(OP_RD, REG_COUNT, '0, '0, CMP_EQ, RESP_OKAY, "counter read");
      add_step(OP_RD, REG_COUNT, '0, '0, CMP_SAME, RESP_OKAY, "counter hold");
      add_step(OP_WR, REG_CTL0, 32'h1 << CTL0_CNT_EN, '0, CMP_NONE, RESP_OKAY,
               "counter enable");
      add_step(OP_RD, REG_COUNT, '0, '0, CMP_NONE, RESP_OKAY, "counter sample");
      add_step(OP_RD, REG_COUNT, '0, '0, CMP_MORE, RESP_OKAY, "counter advance");
      add_step(OP_BURST, REG_SCRATCH1, '0, '0, CMP_NONE, RESP_OKAY, "scratch burst");
   endtask

   task automatic check_value(input int step, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch step %0d %s: got %08h expected %08h", step, name, got, exp);
         step_err++;
      end
   endtask

   // One request held until the engine takes it
   task automatic send_request(input logic wr, input logic [31:0] addr,
                               input logic [31:0] data);
      @(posedge clk_out);
      req_valid_i <= 1'b1;
      req_write_i <= wr;
      req_addr_i  <= addr;
      req_wdata_i <= data;
      do begin
         @(negedge clk_out);
      end while (!req_ready_o);
      @(posedge clk_out);
      req_valid_i <= 1'b0;
   endtask

   task automatic wait_write_done(output axi_resp_t resp);
      do begin
         @(negedge clk_out);
      end while (!wr_done_o);
      resp = wr_resp_o;
   endtask

   task automatic wait_read_data(output logic [31:0] data, output axi_resp_t resp);
      do begin
         @(negedge clk_out);
      end while (!rd_valid_o);
      data = rd_data_o;
      resp = rd_resp_o;
   endtask

   task automatic report_step(input int step, input string label);
      if (step_err == 0) begin
         pass_cnt++;
         $display("step %0d %s: ok", step, label);
      end else begin
         fail_cnt++;
         $display("step %0d %s: %0d error(s)", step, label, step_err);
      end
   endtask

   // ----------------------------------------
   // Test steps
   // ----------------------------------------
   task automatic check_reset_state();
      step_err = 0;
      @(negedge clk_out);
      check_value(0, "req_ready_o", 32'(req_ready_o), 32'h1);
      check_value(0, "wr_done_o", 32'(wr_done_o), 32'h0);
      check_value(0, "rd_valid_o", 32'(rd_valid_o), 32'h0);
      check_value(0, "cl_ctl_o", cl_ctl_o, 32'h0);
      report_step(0, "reset state");
   endtask

   task automatic run_access_step(input int idx);
      logic [31:0] data;
      axi_resp_t   resp;
      if (op_tab[idx] == OP_WR) begin
         send_request(1'b1, addr_tab[idx], wdata_tab[idx]);
         wait_write_done(resp);
         check_value(idx + 1, "wr_resp_o", 32'(resp), 32'(resp_tab[idx]));
         if (mode_tab[idx] == CMP_CTL) begin
            check_value(idx + 1, "cl_ctl_o", cl_ctl_o, wdata_tab[idx]);
         end
      end else begin
         send_request(1'b0, addr_tab[idx], '0);
         wait_read_data(data, resp);
         check_value(idx + 1, "rd_resp_o", 32'(resp), 32'(resp_tab[idx]));
         if (mode_tab[idx] == CMP_EQ) begin
            check_value(idx + 1, "rd_data_o", data, exp_tab[idx]);
         end
         if (mode_tab[idx] == CMP_SAME) begin
            check_value(idx + 1, "rd_data_o", data, last_rd);
         end
         if (mode_tab[idx] == CMP_MORE && data <= last_rd) begin
            $display("mismatch step %0d rd_data_o: got %08h expected above %08h",
                     idx + 1, data, last_rd);
            step_err++;
         end
         last_rd = data;
      end
   endtask

   // Back-to-back writes issued as fast as req_ready_o allows
   task automatic run_burst_step(input int idx);
      logic [31:0] burst_data [FIFO_DEPTH+2];
      logic [31:0] data;
      axi_resp_t   resp;
      logic        accept;
      int          n;
      int          sent;
      int          done;
      int          extra;
      n     = FIFO_DEPTH + 2;
      sent  = 0;
      done  = 0;
      extra = 0;
      for (int i = 0; i < n; i++) begin
         burst_data[i] = next_random();
      end
      @(posedge clk_out);
      req_valid_i <= 1'b1;
      req_write_i <= 1'b1;
      req_addr_i  <= addr_tab[idx];
      req_wdata_i <= burst_data[0];
      while (done < n) begin
         @(negedge clk_out);
         if (wr_done_o) begin
            done++;
            check_value(idx + 1, "wr_resp_o", 32'(wr_resp_o), 32'(RESP_OKAY));
         end
         accept = req_valid_i && req_ready_o;
         @(posedge clk_out);
         if (accept) begin
            sent++;
            if (sent < n) begin
               req_wdata_i <= burst_data[sent];
            end else begin
               req_valid_i <= 1'b0;
            end
         end
      end
      // No completion may follow the last expected one
      repeat (20) begin
         @(negedge clk_out);
         if (wr_done_o) begin
            extra++;
         end
      end
      if (extra != 0) begin
         $display("step %0d: %0d write completions arrived beyond the %0d issued",
                  idx + 1, extra, n);
         step_err++;
      end
      send_request(1'b0, addr_tab[idx], '0);
      wait_read_data(data, resp);
      check_value(idx + 1, "rd_resp_o", 32'(resp), 32'(RESP_OKAY));
      check_value(idx + 1, "rd_data_o", data, burst_data[n-1]);
      last_rd = data;
   endtask

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------
   initial begin
      arst_n_i    = 1'b0;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      cl_status_i = '0;
      rnd_state   = SEED;
      last_rd     = '0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      build_table();
      repeat (2) @(posedge clk_out);
      arst_n_i    <= 1'b1;
      cl_status_i <= STATUS_VALUE;
      check_reset_state();
      for (int i = 0; i < N_STEPS; i++) begin
         step_err = 0;
         if (op_tab[i] == OP_BURST) begin
            run_burst_step(i);
         end else begin
            run_access_step(i);
         end
         report_step(i + 1, label_tab[i]);
      end
      $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      repeat (N_STEPS * CYCLES_PER_STEP) @(posedge clk_out);
      $display("timeout: the run did not finish within %0d cycles",
               N_STEPS * CYCLES_PER_STEP);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire
